//--- source/d_domain_defs.svh
`ifndef D_DOMAIN_DEFS_SVH
`define D_DOMAIN_DEFS_SVH

// command word layout
`define CMD_W        32
`define OPCODE_W     15
`define PAYLOAD_W    17

// memory application port
`define DATA_W       256
`define MASK_W       32
`define APP_ADDR_W   29

// one 256-bit beat covers eight address units
`define BEAT_STRIDE  8

// words per configuration round, count runs 0 to 39
`define CONFIG_WORDS 40

// opcodes
`define OP_CONFIG       1
`define OP_CONFIG_DONE  2
`define OP_CALIB_DONE   3
`define OP_WRITE_ADDR   4
`define OP_CHECK_RESULT 5
`define OP_WRITE_COUNT  6

`endif

//--- source/d_domain_pkg.sv
`include "d_domain_defs.svh"

package d_domain_pkg;

    typedef enum logic [`OPCODE_W-1:0] {
        CMD_CONFIG       = `OP_CONFIG,
        CMD_CONFIG_DONE  = `OP_CONFIG_DONE,
        CMD_CALIB_DONE   = `OP_CALIB_DONE,
        CMD_WRITE_ADDR   = `OP_WRITE_ADDR,
        CMD_CHECK_RESULT = `OP_CHECK_RESULT,
        CMD_WRITE_COUNT  = `OP_WRITE_COUNT
    } cmd_opcode_e;

    // payload sits above the opcode
    typedef struct packed {
        logic [`PAYLOAD_W-1:0] payload;
        logic [`OPCODE_W-1:0]  opcode;
    } cmd_word_t;

    typedef struct packed {
        logic [1:0]  asic_mode;
        logic [15:0] training_epochs;
        logic [15:0] inference_epochs;
        logic [1:0]  dataset;
        logic [15:0] timesteps;
        logic [15:0] input_size_layer1;
        logic        long_time_streaming;
        logic        binary_classifier;
        logic        loser_encourage;
    } asic_config_t;

    typedef enum logic [2:0] {
        APP_WRITE = 3'd0,
        APP_READ  = 3'd1
    } app_cmd_e;

    typedef struct packed {
        logic                   en;
        app_cmd_e               cmd;
        logic [`APP_ADDR_W-1:0] addr;
        logic                   wdf_wren;
        logic [`DATA_W-1:0]     wdf_data;
        logic                   wdf_end;
        logic [`MASK_W-1:0]     wdf_mask;
    } app_req_t;

    typedef enum logic [1:0] {
        CHECK_IDLE,
        CHECK_READ,
        CHECK_WAIT,
        CHECK_REPORT
    } check_state_e;

endpackage

//--- source/command_dispatch.sv
`include "d_domain_defs.svh"

module command_dispatch import d_domain_pkg::*; (
    input  logic                   ui_clk,
    input  logic                   reset,
    input  cmd_word_t              p2d_cmd_dout,
    input  logic                   p2d_cmd_valid,
    input  cmd_word_t              a2d_cmd_dout,
    input  logic                   a2d_cmd_valid,
    input  logic                   p2d_data_valid,
    input  logic                   app_rdy,
    input  logic                   app_wdf_rdy,
    input  logic                   d2p_cmd_full,
    input  logic                   d2a_cmd_full,
    input  logic                   init_calib_complete,
    input  logic                   config_full,
    input  logic                   addr_final,
    input  logic [`APP_ADDR_W-1:0] write_count,
    input  logic                   read_req,
    input  logic                   report_req,
    input  logic [15:0]            result,
    output logic                   p2d_cmd_rd_en,
    output logic                   a2d_cmd_rd_en,
    output logic                   p2d_data_rd_en,
    output logic                   d2p_cmd_wr_en,
    output cmd_word_t              d2p_cmd_din,
    output logic                   d2a_cmd_wr_en,
    output logic [`CMD_W-1:0]      d2a_cmd_din,
    output logic                   cfg_load,
    output logic                   addr_load,
    output logic [`PAYLOAD_W-1:0]  load_payload,
    output logic                   write_go,
    output logic                   config_clear,
    output logic                   report_grant
);

    cmd_opcode_e p2d_op;
    cmd_opcode_e a2d_op;
    logic        calib_sent;
    logic        want_count;
    logic        want_forward;
    logic        want_addr_rpt;
    logic        want_calib;
    logic        grant_count;
    logic        grant_forward;
    logic        grant_addr_rpt;
    logic        grant_calib;

    assign p2d_op = cmd_opcode_e'(p2d_cmd_dout.opcode);
    assign a2d_op = cmd_opcode_e'(a2d_cmd_dout.opcode);
    assign load_payload = p2d_cmd_dout.payload;
    assign d2a_cmd_din = p2d_cmd_dout;

    assign want_count = p2d_cmd_valid && p2d_op == CMD_WRITE_COUNT;
    assign want_forward = a2d_cmd_valid && a2d_op == CMD_CONFIG_DONE && config_full;
    assign want_addr_rpt = p2d_cmd_valid && p2d_op == CMD_WRITE_ADDR && addr_final;
    assign want_calib = init_calib_complete && !calib_sent;

    // fixed priority, check result first
    assign report_grant = !d2p_cmd_full && report_req;
    assign grant_count = !d2p_cmd_full && !report_req && want_count;
    assign grant_forward = !d2p_cmd_full && !report_req && !want_count && want_forward;
    assign grant_addr_rpt = !d2p_cmd_full && !report_req && !want_count && !want_forward
        && want_addr_rpt;
    assign grant_calib = !d2p_cmd_full && !report_req && !want_count && !want_forward
        && !want_addr_rpt && want_calib;

    assign d2p_cmd_wr_en = report_grant || grant_count || grant_forward || grant_addr_rpt
        || grant_calib;

    always_comb begin
        d2p_cmd_din = '0;
        if (report_grant) begin
            d2p_cmd_din.payload = {1'b0, result};
            d2p_cmd_din.opcode = CMD_CHECK_RESULT;
        end else if (grant_count) begin
            d2p_cmd_din.payload = write_count[`PAYLOAD_W-1:0];
            d2p_cmd_din.opcode = CMD_WRITE_COUNT;
        end else if (grant_forward) begin
            d2p_cmd_din = a2d_cmd_dout;
        end else if (grant_addr_rpt) begin
            d2p_cmd_din.opcode = CMD_WRITE_ADDR;
        end else if (grant_calib) begin
            d2p_cmd_din.opcode = CMD_CALIB_DONE;
        end
    end

    // forwarding config done re-arms capture, other a2d words are dropped
    assign config_clear = grant_forward;
    assign a2d_cmd_rd_en = grant_forward || (a2d_cmd_valid && a2d_op != CMD_CONFIG_DONE);

    always_comb begin
        p2d_cmd_rd_en = 1'b0;
        d2a_cmd_wr_en = 1'b0;
        cfg_load = 1'b0;
        addr_load = 1'b0;
        if (p2d_cmd_valid) begin
            case (p2d_op)
                CMD_CONFIG: begin
                    if (!config_full && !d2a_cmd_full) begin
                        p2d_cmd_rd_en = 1'b1;
                        d2a_cmd_wr_en = 1'b1;
                        cfg_load = 1'b1;
                    end
                end
                CMD_WRITE_ADDR: begin
                    // last half waits for its report slot
                    if (!addr_final || grant_addr_rpt) begin
                        p2d_cmd_rd_en = 1'b1;
                        addr_load = 1'b1;
                    end
                end
                CMD_WRITE_COUNT: p2d_cmd_rd_en = grant_count;
                default: p2d_cmd_rd_en = 1'b1;
            endcase
        end
    end

    // beats stream while the check read is not waiting for the port
    assign write_go = p2d_data_valid && app_rdy && app_wdf_rdy && !read_req;
    assign p2d_data_rd_en = write_go;

    always_ff @(posedge ui_clk) begin
        if (reset) begin
            calib_sent <= 1'b0;
        end else if (grant_calib) begin
            calib_sent <= 1'b1;
        end
    end

    // a report must never overrun a full d2p FIFO
    assert property (@(posedge ui_clk) disable iff (reset)
        d2p_cmd_full |-> !d2p_cmd_wr_en);

endmodule

//--- source/config_capture.sv
`include "d_domain_defs.svh"

module config_capture import d_domain_pkg::*; (
    input  logic                  ui_clk,
    input  logic                  reset,
    input  logic                  cfg_load,
    input  logic                  config_clear,
    input  logic [`PAYLOAD_W-1:0] load_payload,
    output asic_config_t          cfg,
    output logic                  config_full
);

    localparam int CNT_W = $clog2(`CONFIG_WORDS);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`CONFIG_WORDS - 1);

    logic [CNT_W-1:0] cfg_cnt;
    logic             last_taken;

    // full once the word at the last count is in
    assign config_full = (cfg_cnt == LAST_CNT) && last_taken;

    always_ff @(posedge ui_clk) begin
        if (reset || config_clear) begin
            cfg_cnt <= '0;
            last_taken <= 1'b0;
        end else if (cfg_load) begin
            if (cfg_cnt == LAST_CNT) begin
                last_taken <= 1'b1;
            end else begin
                cfg_cnt <= cfg_cnt + 1'b1;
            end
        end
    end

    // counts 0 to 8 carry fields, the rest only advance
    always_ff @(posedge ui_clk) begin
        if (reset) begin
            cfg <= '0;
        end else if (cfg_load) begin
            case (cfg_cnt)
                0: cfg.asic_mode <= load_payload[1:0];
                1: cfg.training_epochs <= load_payload[15:0];
                2: cfg.inference_epochs <= load_payload[15:0];
                3: cfg.dataset <= load_payload[1:0];
                4: cfg.timesteps <= load_payload[15:0];
                5: cfg.input_size_layer1 <= load_payload[15:0];
                6: cfg.long_time_streaming <= load_payload[0];
                7: cfg.binary_classifier <= load_payload[0];
                8: cfg.loser_encourage <= load_payload[0];
                default: ;
            endcase
        end
    end

    // dispatch holds config words until the accelerator reports done
    assert property (@(posedge ui_clk) disable iff (reset)
        config_full |-> !cfg_load);

endmodule

//--- source/dram_write_path.sv
`include "d_domain_defs.svh"

module dram_write_path import d_domain_pkg::*; (
    input  logic                   ui_clk,
    input  logic                   reset,
    input  logic                   addr_load,
    input  logic                   write_go,
    input  logic [`PAYLOAD_W-1:0]  load_payload,
    input  logic [`DATA_W-1:0]     p2d_data_dout,
    output logic                   addr_final,
    output logic [`APP_ADDR_W-1:0] write_count,
    output logic [31:0]            last_addr,
    output logic                   finish,
    output app_req_t               write_req
);

    logic [1:0]             xfer_cnt;
    logic [31:0]            base_addr;
    logic [`APP_ADDR_W-1:0] beat_addr;

    // base low, base high, last low, last high
    assign addr_final = (xfer_cnt == 2'd3);
    assign beat_addr = base_addr[`APP_ADDR_W-1:0] + write_count;

    always_ff @(posedge ui_clk) begin
        if (reset) begin
            xfer_cnt <= 2'd0;
        end else if (addr_load) begin
            xfer_cnt <= xfer_cnt + 2'd1;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (addr_load) begin
            case (xfer_cnt)
                2'd0: base_addr[15:0] <= load_payload[15:0];
                2'd1: base_addr[31:16] <= load_payload[15:0];
                2'd2: last_addr[15:0] <= load_payload[15:0];
                default: last_addr[31:16] <= load_payload[15:0];
            endcase
        end
    end

    // new burst restarts the beat offset
    always_ff @(posedge ui_clk) begin
        if (reset) begin
            write_count <= '0;
        end else if (addr_load && xfer_cnt == 2'd0) begin
            write_count <= '0;
        end else if (write_go) begin
            write_count <= write_count + `APP_ADDR_W'(`BEAT_STRIDE);
        end
    end

    // request is zero when idle so the top can OR it with the read
    always_ff @(posedge ui_clk) begin
        if (reset) begin
            write_req <= '0;
            finish <= 1'b0;
        end else begin
            write_req <= '0;
            finish <= 1'b0;
            if (write_go) begin
                write_req.en <= 1'b1;
                write_req.cmd <= APP_WRITE;
                write_req.addr <= beat_addr;
                write_req.wdf_wren <= 1'b1;
                write_req.wdf_data <= p2d_data_dout;
                write_req.wdf_end <= 1'b1;
                write_req.wdf_mask <= '0;
                finish <= ((base_addr + 32'(write_count)) == last_addr);
            end
        end
    end

endmodule

//--- source/readback_check.sv
`include "d_domain_defs.svh"

module readback_check import d_domain_pkg::*; (
    input  logic               ui_clk,
    input  logic               reset,
    input  logic               finish,
    input  logic [31:0]        last_addr,
    input  logic               app_rdy,
    input  logic               app_rd_data_valid,
    input  logic [`DATA_W-1:0] app_rd_data,
    input  logic               report_grant,
    output logic               read_req,
    output app_req_t           read_cmd,
    output logic               report_req,
    output logic [15:0]        result
);

    check_state_e state;

    assign read_req = (state == CHECK_READ);
    assign report_req = (state == CHECK_REPORT);

    always_ff @(posedge ui_clk) begin
        if (reset) begin
            state <= CHECK_IDLE;
            read_cmd <= '0;
        end else begin
            read_cmd <= '0;
            case (state)
                CHECK_IDLE: if (finish) state <= CHECK_READ;
                CHECK_READ: begin
                    if (app_rdy) begin
                        read_cmd.en <= 1'b1;
                        read_cmd.cmd <= APP_READ;
                        read_cmd.addr <= last_addr[`APP_ADDR_W-1:0];
                        state <= CHECK_WAIT;
                    end
                end
                CHECK_WAIT: if (app_rd_data_valid) state <= CHECK_REPORT;
                CHECK_REPORT: if (report_grant) state <= CHECK_IDLE;
                default: state <= CHECK_IDLE;
            endcase
        end
    end

    // first returned beat only
    always_ff @(posedge ui_clk) begin
        if (state == CHECK_WAIT && app_rd_data_valid) begin
            result <= app_rd_data[15:0];
        end
    end

    // the write path stays off the last address until the check is done
    assert property (@(posedge ui_clk) disable iff (reset)
        finish |-> state == CHECK_IDLE);

endmodule

//--- source/d_domain_top.sv
`include "d_domain_defs.svh"

module d_domain_top import d_domain_pkg::*; (
    input  logic               ui_clk,
    input  logic               reset,
    output logic               p2d_cmd_rd_en,
    input  cmd_word_t          p2d_cmd_dout,
    input  logic               p2d_cmd_valid,
    output logic               p2d_data_rd_en,
    input  logic [`DATA_W-1:0] p2d_data_dout,
    input  logic               p2d_data_valid,
    output logic               d2p_cmd_wr_en,
    output cmd_word_t          d2p_cmd_din,
    input  logic               d2p_cmd_full,
    output logic               d2a_cmd_wr_en,
    output logic [`CMD_W-1:0]  d2a_cmd_din,
    input  logic               d2a_cmd_full,
    output logic               a2d_cmd_rd_en,
    input  cmd_word_t          a2d_cmd_dout,
    input  logic               a2d_cmd_valid,
    output app_req_t           app_req,
    input  logic               app_rdy,
    input  logic               app_wdf_rdy,
    input  logic               app_rd_data_valid,
    input  logic [`DATA_W-1:0] app_rd_data,
    input  logic               init_calib_complete,
    output asic_config_t       cfg
);

    logic                   cfg_load;
    logic                   addr_load;
    logic [`PAYLOAD_W-1:0]  load_payload;
    logic                   write_go;
    logic                   config_clear;
    logic                   report_grant;
    logic                   config_full;
    logic                   addr_final;
    logic [`APP_ADDR_W-1:0] write_count;
    logic [31:0]            last_addr;
    logic                   finish;
    logic                   read_req;
    logic                   report_req;
    logic [15:0]            result;
    app_req_t               write_req;
    app_req_t               read_cmd;

    // read and write never issue together, idle side is all zero
    assign app_req = app_req_t'(write_req | read_cmd);

    command_dispatch command_dispatch_i (.*);

    config_capture config_capture_i (.*);

    dram_write_path dram_write_path_i (.*);

    readback_check readback_check_i (.*);

endmodule

//--- bench/d_domain_checker.sv
`include "d_domain_defs.svh"

module d_domain_checker import d_domain_pkg::*; (
    input logic              ui_clk,
    input logic              reset,
    input logic              d2p_cmd_wr_en,
    input cmd_word_t         d2p_cmd_din,
    input logic              d2a_cmd_wr_en,
    input logic [`CMD_W-1:0] d2a_cmd_din,
    input app_req_t          app_req,
    input asic_config_t      cfg
);

    cmd_word_t exp_d2p[$];
    logic [`CMD_W-1:0] exp_d2a[$];
    app_req_t exp_app[$];
    int errors = 0;
    int test_errors = 0;
    int tests = 0;
    int failed_tests = 0;
    int checks = 0;
    int d2a_count = 0;
    logic done_forwarded = 1'b0;

    task automatic expect_d2p(cmd_word_t w);
        exp_d2p.push_back(w);
    endtask

    task automatic expect_d2a(logic [`CMD_W-1:0] w);
        exp_d2a.push_back(w);
    endtask

    task automatic expect_app(app_req_t r);
        exp_app.push_back(r);
    endtask

    function automatic int pending();
        return exp_d2p.size() + exp_d2a.size() + exp_app.size();
    endfunction

    task automatic flag_error(string msg);
        $display("%s at time %0t", msg, $time);
        errors++;
        test_errors++;
    endtask

    task automatic compare(string name, logic [511:0] exp, logic [511:0] act);
        checks++;
        if (exp !== act) begin
            $display("[FAIL] time %0t %s expected %0h actual %0h", $time, name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    always @(posedge ui_clk) begin
        if (!reset) begin
            if (d2p_cmd_wr_en) begin
                if (d2p_cmd_din.opcode == `OPCODE_W'(`OP_CONFIG_DONE)) begin
                    done_forwarded = 1'b1;
                end
                if (exp_d2p.size() == 0) flag_error("unexpected word written to the d2p FIFO");
                else compare("d2p_cmd_din", 512'(exp_d2p.pop_front()), 512'(d2p_cmd_din));
            end
            if (d2a_cmd_wr_en) begin
                d2a_count++;
                // a new round only starts once the done word went to the host
                if (d2a_count > `CONFIG_WORDS && !done_forwarded) begin
                    flag_error("configuration word sent before the done word was forwarded");
                end
                if (exp_d2a.size() == 0) flag_error("unexpected word written to the d2a FIFO");
                else compare("d2a_cmd_din", 512'(exp_d2a.pop_front()), 512'(d2a_cmd_din));
            end
            if (app_req.en) begin
                if (exp_app.size() == 0) flag_error("unexpected request on the memory port");
                else compare("app_req", 512'(exp_app.pop_front()), 512'(app_req));
            end
        end
    end

    task automatic check_cfg(asic_config_t exp);
        compare("cfg", 512'(exp), 512'(cfg));
    endtask

    task automatic close_test(string name);
        tests++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            failed_tests++;
        end
        test_errors = 0;
    endtask

    task automatic final_check();
        if (exp_d2p.size() != 0) flag_error("expected d2p words never appeared");
        if (exp_d2a.size() != 0) flag_error("expected d2a words never appeared");
        if (exp_app.size() != 0) flag_error("expected memory requests never appeared");
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
    endtask

endmodule

//--- bench/tb_d_domain.sv
`include "d_domain_defs.svh"

module tb_d_domain import d_domain_pkg::*; ;

    localparam int SRC_CMD  = 0;
    localparam int SRC_DATA = 1;
    localparam int SRC_A2D  = 2;
    localparam int SRC_IDLE = 3;
    localparam logic [31:0] BASE_ADDR = 32'h0000_0100;

    typedef struct packed {
        logic [1:0]         src;
        logic               drain;
        logic               cfg_chk;
        logic [7:0]         gap;
        logic [2:0]         mark;
        logic [`DATA_W-1:0] word;
    } stim_row_t;

    logic ui_clk;
    logic reset;
    logic p2d_cmd_rd_en;
    cmd_word_t p2d_cmd_dout;
    logic p2d_cmd_valid;
    logic p2d_data_rd_en;
    logic [`DATA_W-1:0] p2d_data_dout;
    logic p2d_data_valid;
    logic d2p_cmd_wr_en;
    cmd_word_t d2p_cmd_din;
    logic d2p_cmd_full;
    logic d2a_cmd_wr_en;
    logic [`CMD_W-1:0] d2a_cmd_din;
    logic d2a_cmd_full;
    logic a2d_cmd_rd_en;
    cmd_word_t a2d_cmd_dout;
    logic a2d_cmd_valid;
    app_req_t app_req;
    logic app_rdy;
    logic app_wdf_rdy;
    logic app_rd_data_valid;
    logic [`DATA_W-1:0] app_rd_data;
    logic init_calib_complete;
    asic_config_t cfg;

    integer seed = 29;
    stim_row_t rows[$];
    logic [`CMD_W-1:0] p2d_cmd_q[$];
    logic [`DATA_W-1:0] p2d_data_q[$];
    logic [`CMD_W-1:0] a2d_cmd_q[$];
    logic [`DATA_W-1:0] mem[logic [`APP_ADDR_W-1:0]];
    logic [`APP_ADDR_W-1:0] rd_addr;
    int rd_delay = 0;
    logic pop_cmd;
    logic pop_data;
    logic pop_a2d;
    asic_config_t exp_cfg;
    logic table_ready = 1'b0;

    d_domain_top d_domain_top_i (.*);

    d_domain_checker checker_i (
        .ui_clk(ui_clk), .reset(reset),
        .d2p_cmd_wr_en(d2p_cmd_wr_en), .d2p_cmd_din(d2p_cmd_din),
        .d2a_cmd_wr_en(d2a_cmd_wr_en), .d2a_cmd_din(d2a_cmd_din),
        .app_req(app_req), .cfg(cfg)
    );

    initial begin
        ui_clk = 1'b0;
        forever #2 ui_clk = ~ui_clk;
    end

    function automatic cmd_word_t make_cmd(int op, logic [`PAYLOAD_W-1:0] payload);
        cmd_word_t w;
        w.payload = payload;
        w.opcode = `OPCODE_W'(op);
        return w;
    endfunction

    function automatic string test_name(logic [2:0] mark);
        case (mark)
            1: return "calibration notice";
            2: return "configuration capture";
            3: return "address report";
            4: return "write beats";
            5: return "beat count";
            default: return "readback check";
        endcase
    endfunction

    task automatic add_row(int src, logic [`DATA_W-1:0] word, bit drain, int gap,
                           bit cfg_chk, int mark);
        stim_row_t r;
        r.src = 2'(src);
        r.word = word;
        r.drain = drain;
        r.gap = 8'(gap);
        r.cfg_chk = cfg_chk;
        r.mark = 3'(mark);
        rows.push_back(r);
    endtask

    task automatic build_tables();
        logic [`PAYLOAD_W-1:0] pl[0:40];
        logic [`DATA_W-1:0] beat[0:3];
        cmd_word_t w;
        logic [`APP_ADDR_W-1:0] a;
        app_req_t req;
        checker_i.expect_d2p(make_cmd(`OP_CALIB_DONE, '0));
        add_row(SRC_IDLE, '0, 0, 10, 0, 1);
        for (int i = 0; i < 41; i++) begin
            pl[i] = `PAYLOAD_W'($random(seed));
            w = make_cmd(`OP_CONFIG, pl[i]);
            checker_i.expect_d2a(w);
            add_row(SRC_CMD, `DATA_W'(w), i == 39, (i == 39) ? 4 : 0, i == 39, 0);
        end
        // fields take the low bits of payloads 0 to 8
        exp_cfg.asic_mode = pl[0][1:0];
        exp_cfg.training_epochs = pl[1][15:0];
        exp_cfg.inference_epochs = pl[2][15:0];
        exp_cfg.dataset = pl[3][1:0];
        exp_cfg.timesteps = pl[4][15:0];
        exp_cfg.input_size_layer1 = pl[5][15:0];
        exp_cfg.long_time_streaming = pl[6][0];
        exp_cfg.binary_classifier = pl[7][0];
        exp_cfg.loser_encourage = pl[8][0];
        w = make_cmd(`OP_CONFIG_DONE, `PAYLOAD_W'($random(seed)));
        checker_i.expect_d2p(w);
        add_row(SRC_A2D, `DATA_W'(w), 1, 4, 0, 2);
        // base low, base high, last low, last high
        add_row(SRC_CMD, `DATA_W'(make_cmd(`OP_WRITE_ADDR, {1'b0, BASE_ADDR[15:0]})), 0, 0, 0, 0);
        add_row(SRC_CMD, `DATA_W'(make_cmd(`OP_WRITE_ADDR, {1'b0, BASE_ADDR[31:16]})), 0, 0, 0, 0);
        add_row(SRC_CMD, `DATA_W'(make_cmd(`OP_WRITE_ADDR, 17'(BASE_ADDR[15:0] + 16'd24))),
                0, 0, 0, 0);
        add_row(SRC_CMD, `DATA_W'(make_cmd(`OP_WRITE_ADDR, '0)), 1, 4, 0, 3);
        checker_i.expect_d2p(make_cmd(`OP_WRITE_ADDR, '0));
        for (int n = 0; n < 4; n++) begin
            for (int k = 0; k < 8; k++) begin
                beat[n][k*32 +: 32] = $random(seed);
            end
            a = `APP_ADDR_W'(BASE_ADDR + 32'(`BEAT_STRIDE * n));
            req = '0;
            req.en = 1'b1;
            req.cmd = APP_WRITE;
            req.addr = a;
            req.wdf_wren = 1'b1;
            req.wdf_data = beat[n];
            req.wdf_end = 1'b1;
            checker_i.expect_app(req);
        end
        add_row(SRC_DATA, beat[0], 0, 0, 0, 0);
        add_row(SRC_DATA, beat[1], 1, 4, 0, 0);
        add_row(SRC_CMD, `DATA_W'(make_cmd(`OP_WRITE_COUNT, '0)), 1, 4, 0, 5);
        checker_i.expect_d2p(make_cmd(`OP_WRITE_COUNT, 17'(2 * `BEAT_STRIDE)));
        add_row(SRC_DATA, beat[2], 0, 0, 0, 0);
        add_row(SRC_DATA, beat[3], 1, 4, 0, 4);
        // idle row with drain waits for the outstanding DUT outputs
        add_row(SRC_IDLE, '0, 1, 2, 0, 6);
        req = '0;
        req.en = 1'b1;
        req.cmd = APP_READ;
        req.addr = `APP_ADDR_W'(BASE_ADDR + 32'd24);
        checker_i.expect_app(req);
        checker_i.expect_d2p(make_cmd(`OP_CHECK_RESULT, {1'b0, beat[3][15:0]}));
    endtask

    // FIFO and memory models drive inputs 1 unit after the edge
    always @(posedge ui_clk) begin
        pop_cmd = p2d_cmd_rd_en;
        pop_data = p2d_data_rd_en;
        pop_a2d = a2d_cmd_rd_en;
        if (!reset && app_req.en && app_req.cmd == APP_WRITE) begin
            mem[app_req.addr] = app_req.wdf_data;
        end
        #1;
        if (pop_cmd && p2d_cmd_q.size() != 0) p2d_cmd_q.delete(0);
        if (pop_data && p2d_data_q.size() != 0) p2d_data_q.delete(0);
        if (pop_a2d && a2d_cmd_q.size() != 0) a2d_cmd_q.delete(0);
        p2d_cmd_valid = p2d_cmd_q.size() != 0;
        p2d_cmd_dout = p2d_cmd_valid ? p2d_cmd_q[0] : '0;
        p2d_data_valid = p2d_data_q.size() != 0;
        p2d_data_dout = p2d_data_valid ? p2d_data_q[0] : '0;
        a2d_cmd_valid = a2d_cmd_q.size() != 0;
        a2d_cmd_dout = a2d_cmd_valid ? a2d_cmd_q[0] : '0;
        app_rd_data_valid = 1'b0;
        if (rd_delay > 0) begin
            rd_delay--;
            if (rd_delay == 0) begin
                app_rd_data_valid = 1'b1;
                app_rd_data = mem.exists(rd_addr) ? mem[rd_addr] : '0;
            end
        end
        if (!reset && app_req.en && app_req.cmd == APP_READ) begin
            rd_addr = app_req.addr;
            rd_delay = 3;
        end
        if (!reset) begin
            app_rdy = ($random(seed) & 3) != 0;
            app_wdf_rdy = ($random(seed) & 3) != 0;
            d2p_cmd_full = ($random(seed) & 7) == 0;
            d2a_cmd_full = ($random(seed) & 15) == 0;
        end
    end

    initial begin
        wait (table_ready);
        repeat (200 * rows.size()) @(posedge ui_clk);
        $display("timeout: the stimulus table did not finish in time");
        $display("Regression failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        p2d_cmd_dout = '0;
        p2d_cmd_valid = 1'b0;
        p2d_data_dout = '0;
        p2d_data_valid = 1'b0;
        d2p_cmd_full = 1'b0;
        d2a_cmd_full = 1'b0;
        a2d_cmd_dout = '0;
        a2d_cmd_valid = 1'b0;
        app_rdy = 1'b1;
        app_wdf_rdy = 1'b1;
        app_rd_data_valid = 1'b0;
        app_rd_data = '0;
        init_calib_complete = 1'b0;
        build_tables();
        table_ready = 1'b1;
        repeat (8) @(posedge ui_clk);
        #1;
        reset = 1'b0;
        init_calib_complete = 1'b1;
        foreach (rows[r]) begin
            @(negedge ui_clk);
            case (rows[r].src)
                SRC_CMD: p2d_cmd_q.push_back(rows[r].word[`CMD_W-1:0]);
                SRC_DATA: p2d_data_q.push_back(rows[r].word);
                SRC_A2D: a2d_cmd_q.push_back(rows[r].word[`CMD_W-1:0]);
                default: ;
            endcase
            if (rows[r].drain) begin
                while (p2d_cmd_q.size() + p2d_data_q.size() + a2d_cmd_q.size() != 0
                       || (rows[r].src == SRC_IDLE && checker_i.pending() != 0)) begin
                    @(posedge ui_clk);
                end
            end
            repeat (rows[r].gap) @(posedge ui_clk);
            if (rows[r].cfg_chk) checker_i.check_cfg(exp_cfg);
            if (rows[r].mark != 0) checker_i.close_test(test_name(rows[r].mark));
        end
        checker_i.final_check();
        if (checker_i.errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+source
source/d_domain_pkg.sv
source/command_dispatch.sv
source/config_capture.sv
source/dram_write_path.sv
source/readback_check.sv
source/d_domain_top.sv
bench/d_domain_checker.sv
bench/tb_d_domain.sv
